// File: rv_isa_pkg.sv
/* RV32I base encodings only; no compressed, CSR or M-extension opcodes are defined.
   The format class codes are fixed and shared with the controller. */
package rv_isa_pkg;

    // instruction field widths
    localparam int inst_w     = 32;
    localparam int opcode_w   = 7;
    localparam int funct3_w   = 3;
    localparam int reg_addr_w = 5;

    // major opcodes in inst[6:0]
    localparam logic [opcode_w-1:0] op_imm    = 7'b0010011;
    localparam logic [opcode_w-1:0] op_reg    = 7'b0110011;
    localparam logic [opcode_w-1:0] op_lui    = 7'b0110111;
    localparam logic [opcode_w-1:0] op_auipc  = 7'b0010111;
    localparam logic [opcode_w-1:0] op_jal    = 7'b1101111;
    localparam logic [opcode_w-1:0] op_jalr   = 7'b1100111;
    localparam logic [opcode_w-1:0] op_load   = 7'b0000011;
    localparam logic [opcode_w-1:0] op_store  = 7'b0100011;
    localparam logic [opcode_w-1:0] op_branch = 7'b1100011;

    // funct3 codes in inst[14:12] for the integer ops
    // f3_add also covers sub and jalr
    localparam logic [funct3_w-1:0] f3_add = 3'b000;
    localparam logic [funct3_w-1:0] f3_slt = 3'b010;
    localparam logic [funct3_w-1:0] f3_xor = 3'b100;
    localparam logic [funct3_w-1:0] f3_or  = 3'b110;
    localparam logic [funct3_w-1:0] f3_and = 3'b111;

    // format class key
    typedef enum logic [2:0] {
        fmt_i   = 3'b000,
        fmt_b   = 3'b001,
        fmt_u   = 3'b010,
        fmt_r   = 3'b011,
        fmt_s   = 3'b100,
        fmt_j   = 3'b101,
        fmt_bad = 3'b111
    } inst_fmt_e;

endpackage

// File: core_pkg.sv
/* Core payload types and buffer sizes. out_credits must not exceed the consumer's real
   buffer slots, and in_credits is also the input FIFO depth. */
package core_pkg;
    import rv_isa_pkg::*;

    // data and pc width
    localparam int xlen = 32;

    // credits and buffering
    localparam int in_credits     = 4;
    localparam int out_credits    = 2;
    localparam int out_fifo_depth = 4;
    localparam int out_cnt_w      = $clog2(out_credits + 1);

    typedef enum logic [2:0] {
        alu_add   = 3'd0,
        alu_sub   = 3'd1,
        alu_slt   = 3'd2,
        alu_and   = 3'd3,
        alu_or    = 3'd4,
        alu_xor   = 3'd5,
        alu_passb = 3'd6
    } alu_op_e;

    // operand b select codes
    typedef enum logic [1:0] {
        srcb_reg  = 2'b00,
        srcb_imm  = 2'b01,
        srcb_four = 2'b10
    } src_b_e;

    // one fetched instruction of 64 bits
    typedef struct packed {
        logic [inst_w-1:0] inst;
        logic [xlen-1:0]   pc;
    } inst_req_t;

    // decoded control of 8 bits
    typedef struct packed {
        logic    alu_src_a;
        src_b_e  alu_src_b;
        alu_op_e alu_op;
        logic    reg_write;
        logic    jump;
    } ctrl_t;

    // commit record of 103 bits
    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic                  wb_en;
        logic [xlen-1:0]       wb_data;
        logic                  jump;
        logic [xlen-1:0]       next_pc;
    } commit_t;

endpackage

// File: inst_format_decoder.sv
/* Purely combinational. Unknown opcodes map to fmt_bad with a zero immediate. */
module inst_format_decoder
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  logic [inst_w-1:0] inst,
    output inst_fmt_e         fmt,
    output logic [xlen-1:0]   imm
);
    logic [opcode_w-1:0] opcode;
    logic                known_op;

    assign opcode = inst[6:0];

    // opcode set checked independently of the format case below
    assign known_op = opcode inside {op_imm, op_reg, op_lui, op_auipc, op_jal,
                                     op_jalr, op_load, op_store, op_branch};

    always_comb begin
        case (opcode)
            op_imm, op_load, op_jalr: fmt = fmt_i;
            op_reg:                   fmt = fmt_r;
            op_lui, op_auipc:         fmt = fmt_u;
            op_jal:                   fmt = fmt_j;
            op_store:                 fmt = fmt_s;
            op_branch:                fmt = fmt_b;
            default:                  fmt = fmt_bad;
        endcase
    end

    // the sign bit is always inst[31]
    always_comb begin
        case (fmt)
            fmt_i: imm = {{20{inst[31]}}, inst[31:20]};
            fmt_s: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            // bit 0 of a branch offset is implied zero
            fmt_b: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            fmt_u: imm = {inst[31:12], 12'b0};
            fmt_j: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            // R-type and unknown carry no immediate
            default: imm = '0;
        endcase
    end

    // a supported opcode must never fall through to the bad class
    always_comb begin
        assert (!(known_op && fmt == fmt_bad))
            else $error("known opcode %b decoded as fmt_bad", opcode);
    end

endmodule

// File: core_controller.sv
/* Combinational control. Unsupported funct3 or funct7 codes clear reg_write so the
   instruction retires as a no-op. */
module core_controller
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  logic [inst_w-1:0] inst,
    input  inst_fmt_e         fmt,
    output ctrl_t             ctrl
);
    logic [opcode_w-1:0] opcode;
    logic [funct3_w-1:0] funct3;
    logic                is_jal;
    logic                is_jalr;
    logic                f3_ok;
    logic                f7_ok;

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign is_jal  = (opcode == op_jal);
    // jalr is only recognized with funct3 000
    assign is_jalr = (opcode == op_jalr) && (funct3 == f3_add);

    // only the five integer funct3 codes are executed
    assign f3_ok = funct3 inside {f3_add, f3_slt, f3_xor, f3_or, f3_and};
    // R-type needs funct7 zero, or 0100000 for sub
    assign f7_ok = (inst[31:25] == 7'b0000000) ||
                   (inst[31:25] == 7'b0100000 && funct3 == f3_add);

    // pc as operand a for auipc and jal
    assign ctrl.alu_src_a = (opcode == op_auipc) || is_jal;

    // constant 4 for links, register for R-type, immediate otherwise
    assign ctrl.alu_src_b = (is_jal || is_jalr) ? srcb_four :
                            (fmt == fmt_r)      ? srcb_reg  : srcb_imm;

    assign ctrl.jump = is_jal || is_jalr;

    always_comb begin
        // I/U/R/J write rd, loads excluded since there is no memory
        ctrl.reg_write = fmt inside {fmt_i, fmt_u, fmt_r, fmt_j};
        if (opcode == op_load)
            ctrl.reg_write = 1'b0;
        // jalr with any other funct3 retires as a no-op
        if (opcode == op_jalr && !is_jalr)
            ctrl.reg_write = 1'b0;
        if (opcode == op_imm && !f3_ok)
            ctrl.reg_write = 1'b0;
        if (opcode == op_reg && !(f3_ok && f7_ok))
            ctrl.reg_write = 1'b0;
    end

    always_comb begin
        ctrl.alu_op = alu_add;
        if (opcode == op_lui) begin
            ctrl.alu_op = alu_passb;
        end else if (opcode == op_imm || opcode == op_reg) begin
            case (funct3)
                // bit 30 selects sub for register forms only
                f3_add:  ctrl.alu_op = (opcode == op_reg && inst[30]) ? alu_sub : alu_add;
                f3_slt:  ctrl.alu_op = alu_slt;
                f3_xor:  ctrl.alu_op = alu_xor;
                f3_or:   ctrl.alu_op = alu_or;
                f3_and:  ctrl.alu_op = alu_and;
                default: ctrl.alu_op = alu_add;
            endcase
        end
    end

endmodule

// File: exec_unit.sv
/* Register read, ALU and write-back in one cycle; no forwarding is needed.
   Loads, stores and branches fall through with next_pc at pc+4. */
module exec_unit
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  inst_req_t       req,
    input  inst_fmt_e       fmt,
    input  logic [xlen-1:0] imm,
    input  ctrl_t           ctrl,
    input  logic            fire,
    output commit_t         commit
);
    logic [xlen-1:0]       regs [2**reg_addr_w];
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       rs1_val;
    logic [xlen-1:0]       rs2_val;
    logic [xlen-1:0]       op_a;
    logic [xlen-1:0]       op_b;
    logic [xlen-1:0]       alu_res;
    logic [xlen-1:0]       link_pc;
    logic [xlen-1:0]       jalr_sum;
    logic [xlen-1:0]       next_pc;
    logic                  wb_en;

    assign rs1 = req.inst[19:15];
    assign rs2 = req.inst[24:20];
    assign rd  = req.inst[11:7];

    // x0 reads as zero whatever the array holds
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    // operand select
    // jumps also take pc so the ALU forms the link pc+4
    assign op_a = (ctrl.alu_src_a || ctrl.jump) ? req.pc : rs1_val;
    always_comb begin
        case (ctrl.alu_src_b)
            srcb_reg:  op_b = rs2_val;
            srcb_imm:  op_b = imm;
            srcb_four: op_b = xlen'(4);
            default:   op_b = '0;
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            alu_add:   alu_res = op_a + op_b;
            alu_sub:   alu_res = op_a - op_b;
            alu_slt:   alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_and:   alu_res = op_a & op_b;
            alu_or:    alu_res = op_a | op_b;
            alu_xor:   alu_res = op_a ^ op_b;
            // lui passes the upper immediate through
            alu_passb: alu_res = op_b;
            default:   alu_res = '0;
        endcase
    end

    // next pc
    assign link_pc  = req.pc + xlen'(4);
    assign jalr_sum = rs1_val + imm;
    always_comb begin
        if (ctrl.jump && fmt == fmt_j)
            next_pc = req.pc + imm;
        else if (ctrl.jump)
            next_pc = {jalr_sum[xlen-1:1], 1'b0};
        else
            next_pc = link_pc;
    end

    // writes to x0 are dropped and reported as no write-back
    assign wb_en = ctrl.reg_write && (rd != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++)
                regs[i] <= '0;
        end else if (fire && wb_en) begin
            regs[rd] <= commit.wb_data;
        end
    end

    assign commit = '{
        pc:      req.pc,
        rd:      rd,
        wb_en:   wb_en,
        wb_data: alu_res,
        jump:    ctrl.jump,
        next_pc: next_pc
    };

endmodule

// File: credit_fifo.sv
/* Synchronous FIFO, head valid whenever not empty. Callers must respect full and
   empty: push on full or pop on empty is a protocol error, not back-pressure. */
module credit_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    // storage is written only on push
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap at depth, not at a power of two
            if (push)
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == cnt_w'(depth));

    // with credits, a push on full means the sender overspent
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full)
        else $error("credit_fifo push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty)
        else $error("credit_fifo pop while empty");

endmodule

// File: exec_core_top.sv
/* Fetch must not send without credit; in_credit returns one credit per executed
   instruction, one cycle after the pop. Commits leave in program order. */
module exec_core_top
    import core_pkg::*;
    import rv_isa_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      in_valid,
    input  inst_req_t in_req,
    output logic      in_credit,
    output logic      out_valid,
    output commit_t   out_commit,
    input  logic      out_credit
);
    inst_req_t            in_head;
    logic                 in_empty;
    inst_fmt_e            dec_fmt;
    logic [xlen-1:0]      dec_imm;
    ctrl_t                ctrl;
    commit_t              exec_commit;
    logic                 out_empty;
    logic                 out_full;
    logic                 fire;
    logic                 send;
    logic [out_cnt_w-1:0] credit_cnt;

    // input buffer, one slot per fetch credit
    // an in_valid without credit trips the FIFO overflow assertion
    credit_fifo #(.payload_t(inst_req_t), .depth(in_credits)) u_in_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (in_valid),
        .push_data (in_req),
        .pop       (fire),
        .head      (in_head),
        .empty     (in_empty),
        .full      ()
    );

    inst_format_decoder u_decoder (
        .inst (in_head.inst),
        .fmt  (dec_fmt),
        .imm  (dec_imm)
    );

    core_controller u_controller (
        .inst (in_head.inst),
        .fmt  (dec_fmt),
        .ctrl (ctrl)
    );

    // execute when there is an instruction and room for its commit
    assign fire = !in_empty && !out_full;

    exec_unit u_exec (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (in_head),
        .fmt    (dec_fmt),
        .imm    (dec_imm),
        .ctrl   (ctrl),
        .fire   (fire),
        .commit (exec_commit)
    );

    credit_fifo #(.payload_t(commit_t), .depth(out_fifo_depth)) u_out_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (fire),
        .push_data (exec_commit),
        .pop       (send),
        .head      (out_commit),
        .empty     (out_empty),
        .full      (out_full)
    );

    // send only with a consumer slot in hand
    assign send      = (credit_cnt != '0) && !out_empty;
    assign out_valid = send;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= out_cnt_w'(out_credits);
            in_credit  <= 1'b0;
        end else begin
            case ({send, out_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
            // one returned fetch credit per pop
            in_credit <= fire;
        end
    end

    // a returned credit beyond what was sent would push this past the reset value
    a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        credit_cnt <= out_cnt_w'(out_credits))
        else $error("output credit count above out_credits");

endmodule

// File: tb_exec_core.sv
/* Plays fetch and consumer around exec_core_top, reads exec_core_vectors.txt from the
   working directory; wb_data is compared only where the expected wb_en is set. */
module tb_exec_core import core_pkg::*; ();

    localparam int max_vectors = 64;
    // words per vector line: inst pc rd wb_en wb_data jump next_pc
    localparam int vec_words   = 7;

    logic      clk;
    logic      arst_n;
    logic      in_valid;
    inst_req_t in_req;
    logic      in_credit;
    logic      out_valid;
    commit_t   out_commit;
    logic      out_credit;

    logic [31:0] vec_mem [max_vectors*vec_words];
    int          num_vectors;
    int          timeout_cycles;
    int          cycle_count;
    int          credit_returns;
    int          commits_seen;
    int          credits_applied;
    int          credits_returned;

    exec_core_top dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_commit (out_commit),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // unused words hold a pattern tied to their address to mark the end of the list
    function automatic logic [31:0] fill_word(input int addr);
        return 32'hdead_0000 ^ 32'(addr);
    endfunction

    function automatic commit_t expected_commit(input int idx);
        commit_t c;
        int      base;
        base      = idx * vec_words;
        c.pc      = vec_mem[base + 1];
        c.rd      = vec_mem[base + 2][4:0];
        c.wb_en   = vec_mem[base + 3][0];
        c.wb_data = vec_mem[base + 4];
        c.jump    = vec_mem[base + 5][0];
        c.next_pc = vec_mem[base + 6];
        return c;
    endfunction

    function automatic string commit_text(input commit_t c);
        return $sformatf("pc=%h rd=%0d wb_en=%b wb_data=%h jump=%b next_pc=%h",
                         c.pc, c.rd, c.wb_en, c.wb_data, c.jump, c.next_pc);
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_commit(input string name, input commit_t exp, input commit_t act);
        commit_t seen;
        seen = act;
        // write data has no meaning without a register write
        if (!exp.wb_en)
            seen.wb_data = exp.wb_data;
        if (seen !== exp)
            fail_now($sformatf("Mismatch %s expected %s actual %s",
                               name, commit_text(exp), commit_text(act)));
    endtask

    task automatic check_credit(input logic valid, input int avail);
        if (valid && avail <= 0)
            fail_now($sformatf("out_valid sent with no output credit left (%0d available)",
                               avail));
    endtask

    // load vectors, reset, wait for all commits and give the verdict
    initial begin
        arst_n           = 1'b0;
        in_valid         = 1'b0;
        in_req           = '0;
        out_credit       = 1'b0;
        cycle_count      = 0;
        credit_returns   = 0;
        commits_seen     = 0;
        credits_applied  = 0;
        credits_returned = 0;
        num_vectors      = 0;
        for (int i = 0; i < max_vectors * vec_words; i++)
            vec_mem[i] = fill_word(i);
        $readmemh("exec_core_vectors.txt", vec_mem);
        while (num_vectors < max_vectors &&
               vec_mem[num_vectors*vec_words] != fill_word(num_vectors*vec_words))
            num_vectors++;
        if (num_vectors == 0)
            fail_now("no vectors found in exec_core_vectors.txt");
        timeout_cycles = 20 * num_vectors + 100;
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;
        wait (commits_seen == num_vectors);
        // a few more cycles to catch stray commits or late in_credit pulses
        repeat (4) @(posedge clk);
        if (credit_returns == num_vectors && commits_seen == num_vectors) begin
            $display("Regression passed");
            $finish;
        end else begin
            fail_now($sformatf("%0d in_credit pulses and %0d commits for %0d vectors",
                               credit_returns, commits_seen, num_vectors));
        end
    end

    // fetch agent sends only with credit in hand
    initial begin : fetch
        int fetch_seed;
        int sent;
        fetch_seed = 29;
        sent       = 0;
        wait (arst_n);
        while (sent < num_vectors) begin
            @(posedge clk);
            #2;
            if (in_credits - sent + credit_returns > 0 && ($random(fetch_seed) & 7) != 0) begin
                in_valid = 1'b1;
                in_req   = '{inst: vec_mem[sent*vec_words], pc: vec_mem[sent*vec_words + 1]};
                sent++;
            end else begin
                in_valid = 1'b0;
            end
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    end

    // consumer returns slots at random and holds them all for a long stretch
    initial begin : consumer
        int consumer_seed;
        int cyc;
        consumer_seed = 29;
        cyc           = 0;
        wait (arst_n);
        forever begin
            @(posedge clk);
            #2;
            cyc++;
            out_credit = 1'b0;
            if ((cyc < 10 || cyc >= 70) && commits_seen > credits_returned &&
                ($random(consumer_seed) & 1) != 0) begin
                out_credit = 1'b1;
                credits_returned++;
            end
        end
    end

    // sample mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (arst_n) begin
            if (in_credit)
                credit_returns++;
            if (out_valid) begin
                check_credit(out_valid, out_credits - commits_seen + credits_applied);
                if (commits_seen >= num_vectors)
                    fail_now("commit received beyond the end of the vector list");
                check_commit($sformatf("vec%0d inst %h", commits_seen,
                                       vec_mem[commits_seen*vec_words]),
                             expected_commit(commits_seen), out_commit);
                commits_seen++;
            end
            // a pulse seen now reaches the core at the next edge
            if (out_credit)
                credits_applied++;
        end
    end

    always @(posedge clk) begin
        if (arst_n) begin
            cycle_count++;
            if (cycle_count >= timeout_cycles)
                fail_now($sformatf("timeout after %0d cycles with %0d of %0d commits",
                                   cycle_count, commits_seen, num_vectors));
        end
    end

endmodule

// File: exec_core_vectors.txt
// inst     pc       rd wb_en wb_data  jump next_pc   (all hex, one instruction per line)
// wb_data is a don't-care on lines with wb_en 0
00500093 00000000 01 1 00000005 0 00000004
FFD00113 00000004 02 1 FFFFFFFD 0 00000008
00112193 00000008 03 1 00000001 0 0000000C
0020C233 0000000C 04 1 FFFFFFF8 0 00000010
0030E2B3 00000010 05 1 00000005 0 00000014
00127333 00000014 06 1 00000000 0 00000018
002083B3 00000018 07 1 00000002 0 0000001C
40208433 0000001C 08 1 00000008 0 00000020
001124B3 00000020 09 1 00000001 0 00000024
12345537 00000024 0A 1 12345000 0 00000028
00001597 00000028 0B 1 00001028 0 0000002C
00708013 0000002C 00 0 00000000 0 00000030
00100633 00000030 0C 1 00000005 0 00000034
010006EF 00000034 0D 1 00000038 1 00000044
05540767 00000044 0E 1 00000048 1 0000005C
0000A783 0000005C 0F 0 00000000 0 00000060
00112223 00000060 04 0 00000000 0 00000064
00108463 00000064 08 0 00000000 0 00000068
00170813 00000068 10 1 00000049 0 0000006C
00B688B3 0000006C 11 1 00001060 0 00000070
FFF54913 00000070 12 1 EDCBAFFF 0 00000074
0FF97993 00000074 13 1 000000FF 0 00000078
7009EA13 00000078 14 1 000007FF 0 0000007C

// File: compile.f
rv_isa_pkg.sv
core_pkg.sv
inst_format_decoder.sv
core_controller.sv
exec_unit.sv
credit_fifo.sv
exec_core_top.sv
tb_exec_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the exec core regression with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_exec_core -o sim_exec_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_exec_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Regression passed" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
